// File: compile.f
verilog/exec_pkg.sv
verilog/branch_resolve.sv
verilog/int_alu.sv
verilog/mul_pipe.sv
verilog/div_iter.sv
verilog/wb_arbiter.sv
verilog/exec_stage.sv
dv/exec_tb_assert.sv
dv/exec_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the execute stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f compile.f --top-module exec_tb \
  --Mdir "$build_dir" -o exec_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/exec_tb_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Finished with no errors" "$log_file"; then
  echo "result: pass"
  exit 0
fi

echo "result: fail"
exit 1

// File: dv/exec_tb.sv
// directed testbench for the integer execute stage with its own reference model
`timescale 1ns/1ps

module exec_tb;
  import exec_pkg::*;

  localparam int CLK_HALF    = 50;
  localparam int DRIVE_DELAY = 1;
  localparam int SEED        = 32'h1cab127a;
  localparam int MUL_BURST   = 3;
  localparam int DIV_LIMIT   = 4 * DIV_CYCLES;

  logic     CLK;
  logic     nRST;
  logic     issue_valid;
  fu_sel_t  fu_sel;
  alu_op_t  alu_op;
  mul_op_t  mul_op;
  div_op_t  div_op;
  word_t    port_a;
  word_t    port_b;
  word_t    imm;
  word_t    pc;
  word_t    pc4;
  logic     prediction;
  cb_idx_t  tag;
  reg_idx_t rd;
  logic     alu_block;
  logic     div_busy;
  logic     cb_valid;
  cb_idx_t  cb_tag;
  reg_idx_t cb_rd;
  word_t    cb_wdata;
  logic     cb_wen;
  exc_t     cb_exc;
  logic     redirect_valid;
  word_t    redirect_addr;
  int       err_count;

  initial begin
    CLK = 1'b0;
    forever begin
      #CLK_HALF CLK = ~CLK;
    end
  end

  exec_stage exec_stage_inst (
    .CLK            (CLK),
    .nRST           (nRST),
    .issue_valid    (issue_valid),
    .fu_sel         (fu_sel),
    .alu_op         (alu_op),
    .mul_op         (mul_op),
    .div_op         (div_op),
    .port_a         (port_a),
    .port_b         (port_b),
    .imm            (imm),
    .pc             (pc),
    .pc4            (pc4),
    .prediction     (prediction),
    .tag            (tag),
    .rd             (rd),
    .alu_block      (alu_block),
    .div_busy       (div_busy),
    .cb_valid       (cb_valid),
    .cb_tag         (cb_tag),
    .cb_rd          (cb_rd),
    .cb_wdata       (cb_wdata),
    .cb_wen         (cb_wen),
    .cb_exc         (cb_exc),
    .redirect_valid (redirect_valid),
    .redirect_addr  (redirect_addr)
  );

  // reference model
  function automatic word_t alu_model(alu_op_t op, word_t a, word_t b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      default: return (a < b) ? 32'd1 : 32'd0;
    endcase
  endfunction

  function automatic logic branch_model(alu_op_t cond, word_t a, word_t b);
    logic lt_s;
    logic lt_u;
    lt_s = $signed(a) < $signed(b);
    lt_u = a < b;
    case (cond)
      ADD:     return a == b;
      SUB:     return a != b;
      AND:     return lt_s;
      OR:      return !lt_s;
      XOR:     return lt_u;
      SLL:     return !lt_u;
      default: return 1'b0;
    endcase
  endfunction

  function automatic word_t mul_model(mul_op_t op, word_t a, word_t b);
    logic [2*XLEN-1:0] prod;
    prod = {32'd0, a} * {32'd0, b};
    if (op == MULHU) begin
      return prod[2*XLEN-1:XLEN];
    end
    return prod[XLEN-1:0];
  endfunction

  // zero divisor gives all ones or the dividend
  function automatic word_t div_model(div_op_t op, word_t a, word_t b);
    if (b == 32'd0) begin
      return (op == REMU) ? a : 32'hffff_ffff;
    end
    return (op == REMU) ? (a % b) : (a / b);
  endfunction

  task automatic stop_failed();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic compare(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] time %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_failed();
    end
  endtask

  task automatic next_cycle();
    @(posedge CLK);
    #DRIVE_DELAY;
  endtask

  task automatic idle_inputs();
    issue_valid = 1'b0;
    fu_sel      = FU_ALU;
    alu_op      = ADD;
    mul_op      = MUL;
    div_op      = DIVU;
    port_a      = '0;
    port_b      = '0;
    imm         = '0;
    pc          = '0;
    pc4         = '0;
    prediction  = 1'b0;
    tag         = '0;
    rd          = '0;
  endtask

  task automatic set_issue(input fu_sel_t fu, input word_t a, input word_t b,
                           input cb_idx_t t, input reg_idx_t r);
    issue_valid = 1'b1;
    fu_sel      = fu;
    port_a      = a;
    port_b      = b;
    tag         = t;
    rd          = r;
  endtask

  task automatic end_issue();
    issue_valid = 1'b0;
  endtask

  task automatic expect_writeback(input string what, input cb_idx_t t, input reg_idx_t r,
                                  input word_t data, input logic use_data,
                                  input logic wen, input exc_t exc);
    compare({what, " cb_valid"}, word_t'(cb_valid), 32'd1);
    compare({what, " cb_tag"}, word_t'(cb_tag), word_t'(t));
    compare({what, " cb_rd"}, word_t'(cb_rd), word_t'(r));
    if (use_data) begin
      compare({what, " cb_wdata"}, cb_wdata, data);
    end
    compare({what, " cb_wen"}, word_t'(cb_wen), word_t'(wen));
    compare({what, " cb_exc"}, word_t'(cb_exc), word_t'(exc));
  endtask

  task automatic wait_for_tag(input cb_idx_t t, output int cycles);
    cycles = 0;
    while (!(cb_valid === 1'b1 && cb_tag === t)) begin
      if (cycles >= DIV_LIMIT) begin
        $display("timed out after %0d cycles waiting for the writeback of tag %0d", cycles, t);
        stop_failed();
      end
      next_cycle();
      cycles++;
    end
  endtask

  task automatic reset_values();
    for (int i = 0; i < 3; i++) begin
      compare("reset cb_valid", word_t'(cb_valid), 32'd0);
      compare("reset redirect_valid", word_t'(redirect_valid), 32'd0);
      compare("reset alu_block", word_t'(alu_block), 32'd0);
      compare("reset div_busy", word_t'(div_busy), 32'd0);
      next_cycle();
    end
  endtask

  task automatic alu_random();
    word_t    a;
    word_t    b;
    cb_idx_t  t;
    reg_idx_t r;
    for (int i = 0; i < 40; i++) begin
      a      = $urandom();
      b      = $urandom();
      t      = cb_idx_t'($urandom_range(0, NUM_CB_ENTRY - 1));
      r      = reg_idx_t'($urandom_range(0, 31));
      alu_op = alu_op_t'($urandom_range(0, 7));
      set_issue(FU_ALU, a, b, t, r);
      next_cycle();
      end_issue();
      expect_writeback("alu", t, r, alu_model(alu_op, a, b), 1'b1, 1'b1, EXC_NONE);
      compare("alu redirect_valid", word_t'(redirect_valid), 32'd0);
    end
    next_cycle();
    compare("alu idle cb_valid", word_t'(cb_valid), 32'd0);
  endtask

  task automatic branch_conditions();
    alu_op_t  conds [6] = '{ADD, SUB, AND, OR, XOR, SLL};
    word_t    a;
    word_t    b;
    word_t    base;
    word_t    off;
    logic     taken;
    logic     redir;
    cb_idx_t  t;
    reg_idx_t r;
    foreach (conds[c]) begin
      for (int p = 0; p < 2; p++) begin
        // equal operands hit the boundary of every condition
        for (int same = 0; same < 2; same++) begin
          a          = $urandom();
          b          = (same == 1) ? a : $urandom();
          base       = $urandom() & ~32'd3;
          off        = $urandom() & ~32'd3;
          t          = cb_idx_t'($urandom_range(0, NUM_CB_ENTRY - 1));
          r          = reg_idx_t'($urandom_range(0, 31));
          taken      = branch_model(conds[c], a, b);
          redir      = (taken != p[0]);
          alu_op     = conds[c];
          prediction = p[0];
          imm        = off;
          pc         = base;
          pc4        = base + 32'd4;
          set_issue(FU_BRANCH, a, b, t, r);
          next_cycle();
          end_issue();
          expect_writeback("branch", t, r, '0, 1'b0, 1'b0, EXC_NONE);
          compare("branch redirect_valid", word_t'(redirect_valid), word_t'(redir));
          if (redir) begin
            compare("branch redirect_addr", redirect_addr, taken ? (base + off) : pc4);
          end
        end
      end
    end
  endtask

  task automatic jump_and_link();
    word_t   a;
    word_t   base;
    word_t   off;
    word_t   target;
    cb_idx_t t;
    for (int k = 0; k < 4; k++) begin
      base = $urandom() & ~32'd3;
      off  = $urandom() & ~32'd3;
      a    = $urandom() & ~32'd3;
      t    = cb_idx_t'(k + 3);
      if (k < 2) begin
        alu_op = ADD;
        target = base + off;
      end else begin
        // odd offset checks that bit 0 is cleared
        alu_op = SUB;
        off    = off | word_t'(k % 2);
        target = (a + off) & ~32'd1;
      end
      prediction = 1'b0;
      imm        = off;
      pc         = base;
      pc4        = base + 32'd4;
      set_issue(FU_JUMP, a, $urandom(), t, reg_idx_t'(k + 1));
      next_cycle();
      end_issue();
      expect_writeback("jump", t, reg_idx_t'(k + 1), base + 32'd4, 1'b1, 1'b1, EXC_NONE);
      compare("jump redirect_valid", word_t'(redirect_valid), 32'd1);
      compare("jump redirect_addr", redirect_addr, target);
    end
  endtask

  task automatic misaligned_targets();
    word_t   a;
    word_t   base;
    word_t   off;
    cb_idx_t t;
    for (int k = 0; k < 4; k++) begin
      base       = $urandom() & ~32'd3;
      off        = ($urandom() & ~32'd3) | 32'd2;
      a          = $urandom() & ~32'd3;
      t          = cb_idx_t'(k + 8);
      alu_op     = (k == 3) ? SUB : ADD;
      prediction = (k == 1);
      imm        = off;
      pc         = base;
      pc4        = base + 32'd4;
      set_issue((k < 2) ? FU_BRANCH : FU_JUMP, a, $urandom(), t, 5'd7);
      next_cycle();
      end_issue();
      expect_writeback("misaligned", t, 5'd7, base, 1'b1, 1'b0, EXC_MAL_TARGET);
      compare("misaligned redirect_valid", word_t'(redirect_valid), 32'd0);
    end
  endtask

  task automatic mul_back_to_back();
    word_t   ma [MUL_BURST];
    word_t   mb [MUL_BURST];
    mul_op_t ops [MUL_BURST];
    cb_idx_t tags [MUL_BURST];
    int      done_idx;
    int      block_idx;
    for (int round = 0; round < 2; round++) begin
      for (int k = 0; k < MUL_BURST + MUL_STAGES; k++) begin
        if (k < MUL_BURST) begin
          ma[k]   = $urandom();
          mb[k]   = $urandom();
          ops[k]  = mul_op_t'((k + round) % 2);
          tags[k] = cb_idx_t'(4 * round + k);
          mul_op  = ops[k];
          set_issue(FU_MUL, ma[k], mb[k], tags[k], reg_idx_t'(k + 1));
        end else begin
          end_issue();
        end
        next_cycle();
        // block rises one cycle ahead of each writeback
        done_idx  = k - (MUL_STAGES - 1);
        block_idx = k - (MUL_STAGES - 2);
        compare("mul alu_block", word_t'(alu_block),
                word_t'(block_idx >= 0 && block_idx < MUL_BURST));
        if (done_idx >= 0 && done_idx < MUL_BURST) begin
          expect_writeback("mul", tags[done_idx], reg_idx_t'(done_idx + 1),
                           mul_model(ops[done_idx], ma[done_idx], mb[done_idx]),
                           1'b1, 1'b1, EXC_NONE);
        end else begin
          compare("mul idle cb_valid", word_t'(cb_valid), 32'd0);
        end
      end
    end
  endtask

  task automatic divide_cases();
    word_t   da [7];
    word_t   db [7];
    div_op_t dop [7];
    int      waited;
    cb_idx_t t;
    da[0]  = $urandom();
    db[0]  = $urandom_range(1, 65535);
    dop[0] = DIVU;
    da[1]  = $urandom();
    db[1]  = $urandom_range(1, 65535);
    dop[1] = REMU;
    da[2]  = $urandom();
    db[2]  = 32'd0;
    dop[2] = DIVU;
    da[3]  = $urandom();
    db[3]  = 32'd0;
    dop[3] = REMU;
    da[4]  = 32'd1234;
    db[4]  = $urandom() | 32'h8000_0000;
    dop[4] = DIVU;
    da[5]  = $urandom();
    db[5]  = 32'd1;
    dop[5] = REMU;
    da[6]  = 32'hffff_ffff;
    db[6]  = 32'hffff_ffff;
    dop[6] = DIVU;
    for (int k = 0; k < 7; k++) begin
      t      = cb_idx_t'(k + 1);
      div_op = dop[k];
      set_issue(FU_DIV, da[k], db[k], t, reg_idx_t'(k + 20));
      next_cycle();
      end_issue();
      compare("div busy after issue", word_t'(div_busy), 32'd1);
      wait_for_tag(t, waited);
      compare("div latency", word_t'(waited + 1), word_t'(DIV_CYCLES));
      expect_writeback("div", t, reg_idx_t'(k + 20), div_model(dop[k], da[k], db[k]),
                       1'b1, 1'b1, EXC_NONE);
      next_cycle();
      compare("div busy after writeback", word_t'(div_busy), 32'd0);
      compare("div idle cb_valid", word_t'(cb_valid), 32'd0);
    end
  endtask

  task automatic divide_behind_muls();
    cb_idx_t seen [$];
    word_t   ma [MUL_BURST];
    word_t   mb [MUL_BURST];
    word_t   a;
    word_t   b;
    int      first_mul;
    int      step;
    int      idx;
    logic    div_seen;
    a = $urandom();
    b = $urandom_range(1, 255);
    for (int k = 0; k < MUL_BURST; k++) begin
      ma[k] = $urandom();
      mb[k] = $urandom();
    end
    div_op = REMU;
    set_issue(FU_DIV, a, b, cb_idx_t'(9), 5'd17);
    next_cycle();
    end_issue();
    // first multiply writes back in the divider's first done cycle
    first_mul = DIV_CYCLES - MUL_STAGES;
    step      = 0;
    div_seen  = 1'b0;
    while (!div_seen) begin
      if (step >= DIV_LIMIT) begin
        $display("timed out after %0d cycles waiting for the divide behind the multiplies", step);
        stop_failed();
      end
      step++;
      if (step >= first_mul && step < first_mul + MUL_BURST) begin
        idx    = step - first_mul;
        mul_op = mul_op_t'(idx % 2);
        set_issue(FU_MUL, ma[idx], mb[idx], cb_idx_t'(10 + idx), reg_idx_t'(idx + 1));
      end else begin
        end_issue();
      end
      next_cycle();
      if (cb_valid === 1'b1) begin
        idx = seen.size();
        seen.push_back(cb_tag);
        if (cb_tag === cb_idx_t'(9)) begin
          div_seen = 1'b1;
          expect_writeback("overlap div", cb_idx_t'(9), 5'd17, div_model(REMU, a, b),
                           1'b1, 1'b1, EXC_NONE);
        end else begin
          compare("mul writebacks ahead of the divide", word_t'(idx < MUL_BURST), 32'd1);
          expect_writeback("overlap mul", cb_idx_t'(10 + idx), reg_idx_t'(idx + 1),
                           mul_model(mul_op_t'(idx % 2), ma[idx], mb[idx]),
                           1'b1, 1'b1, EXC_NONE);
        end
      end
    end
    compare("overlap writeback count", word_t'(seen.size()), word_t'(MUL_BURST + 1));
    compare("overlap divide cycle", word_t'(step), word_t'(DIV_CYCLES - 1 + MUL_BURST));
    next_cycle();
    compare("overlap div busy", word_t'(div_busy), 32'd0);
  endtask

  initial begin
    err_count = 0;
    void'($urandom(SEED));
    idle_inputs();
    nRST = 1'b0;
    repeat (2) @(posedge CLK);
    #DRIVE_DELAY;
    nRST = 1'b1;

    reset_values();
    alu_random();
    branch_conditions();
    jump_and_link();
    misaligned_targets();
    mul_back_to_back();
    divide_cases();
    divide_behind_muls();
    next_cycle();

    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: dv/exec_tb_assert.sv
// issue rule and writeback port assertions bound into the execute stage
`timescale 1ns/1ps

module exec_tb_assert (
  input logic              CLK,
  input logic              nRST,
  input logic              issue_valid,
  input exec_pkg::fu_sel_t fu_sel,
  input logic              alu_block,
  input logic              div_busy,
  input logic              cb_valid,
  input logic              redirect_valid
);
  import exec_pkg::*;

  logic alu_class;
  logic div_issue;

  assign alu_class = issue_valid &&
                     ((fu_sel == FU_ALU) || (fu_sel == FU_BRANCH) || (fu_sel == FU_JUMP));
  assign div_issue = issue_valid && (fu_sel == FU_DIV);

  // alu_block warns of a multiply writeback in the next cycle
  alu_issue_blocked: assert property (@(posedge CLK) disable iff (!nRST)
    alu_class |-> !alu_block)
    else $error("ALU, branch or jump issued while alu_block is high");

  div_issue_blocked: assert property (@(posedge CLK) disable iff (!nRST)
    div_issue |-> !div_busy)
    else $error("divide issued while div_busy is high");

  cb_valid_known: assert property (@(posedge CLK) disable iff (!nRST)
    !$isunknown(cb_valid))
    else $error("cb_valid is unknown after reset");

  // a second redirect needs a second issue
  redirect_single: assert property (@(posedge CLK) disable iff (!nRST)
    (redirect_valid && !issue_valid) |=> !redirect_valid)
    else $error("redirect_valid high two cycles in a row without a new issue");

endmodule

bind exec_stage exec_tb_assert exec_tb_assert_inst (
  .CLK            (CLK),
  .nRST           (nRST),
  .issue_valid    (issue_valid),
  .fu_sel         (fu_sel),
  .alu_block      (alu_block),
  .div_busy       (div_busy),
  .cb_valid       (cb_valid),
  .redirect_valid (redirect_valid)
);

// File: verilog/exec_stage.sv
// integer execute stage joining the ALU, branch, multiply and divide paths to one writeback port
`timescale 1ns/1ps

module exec_stage (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                issue_valid,
  input  exec_pkg::fu_sel_t   fu_sel,
  input  exec_pkg::alu_op_t   alu_op,
  input  exec_pkg::mul_op_t   mul_op,
  input  exec_pkg::div_op_t   div_op,
  input  exec_pkg::word_t     port_a,
  input  exec_pkg::word_t     port_b,
  input  exec_pkg::word_t     imm,
  input  exec_pkg::word_t     pc,
  input  exec_pkg::word_t     pc4,
  input  logic                prediction,
  input  exec_pkg::cb_idx_t   tag,
  input  exec_pkg::reg_idx_t  rd,
  output logic                alu_block,
  output logic                div_busy,
  output logic                cb_valid,
  output exec_pkg::cb_idx_t   cb_tag,
  output exec_pkg::reg_idx_t  cb_rd,
  output exec_pkg::word_t     cb_wdata,
  output logic                cb_wen,
  output exec_pkg::exc_t      cb_exc,
  output logic                redirect_valid,
  output exec_pkg::word_t     redirect_addr
);
  import exec_pkg::*;

  logic     mal_target;

  logic     alu_done;
  cb_idx_t  alu_tag;
  reg_idx_t alu_rd;
  word_t    alu_wdata;
  logic     alu_wen;
  exc_t     alu_exc;

  logic     mul_done;
  cb_idx_t  mul_tag;
  reg_idx_t mul_rd;
  word_t    mul_wdata;

  logic     div_done;
  cb_idx_t  div_tag;
  reg_idx_t div_rd;
  word_t    div_wdata;
  logic     div_grant;

  branch_resolve branch_resolve_inst (
    .CLK            (CLK),
    .nRST           (nRST),
    .issue_valid    (issue_valid),
    .fu_sel         (fu_sel),
    .alu_op         (alu_op),
    .port_a         (port_a),
    .port_b         (port_b),
    .imm            (imm),
    .pc             (pc),
    .pc4            (pc4),
    .prediction     (prediction),
    .redirect_valid (redirect_valid),
    .redirect_addr  (redirect_addr),
    .mal_target     (mal_target),
    .link_sel       ()
  );

  int_alu int_alu_inst (
    .CLK         (CLK),
    .nRST        (nRST),
    .issue_valid (issue_valid),
    .fu_sel      (fu_sel),
    .alu_op      (alu_op),
    .port_a      (port_a),
    .port_b      (port_b),
    .pc          (pc),
    .pc4         (pc4),
    .tag         (tag),
    .rd          (rd),
    .mal_target  (mal_target),
    .done        (alu_done),
    .tag_out     (alu_tag),
    .rd_out      (alu_rd),
    .wdata       (alu_wdata),
    .wen         (alu_wen),
    .exc         (alu_exc)
  );

  // stage-two valid doubles as the ALU issue block
  mul_pipe mul_pipe_inst (
    .CLK         (CLK),
    .nRST        (nRST),
    .issue_valid (issue_valid),
    .fu_sel      (fu_sel),
    .mul_op      (mul_op),
    .port_a      (port_a),
    .port_b      (port_b),
    .tag         (tag),
    .rd          (rd),
    .done        (mul_done),
    .tag_out     (mul_tag),
    .rd_out      (mul_rd),
    .wdata       (mul_wdata),
    .near_done   (alu_block)
  );

  div_iter div_iter_inst (
    .CLK         (CLK),
    .nRST        (nRST),
    .issue_valid (issue_valid),
    .fu_sel      (fu_sel),
    .div_op      (div_op),
    .port_a      (port_a),
    .port_b      (port_b),
    .tag         (tag),
    .rd          (rd),
    .grant       (div_grant),
    .busy        (div_busy),
    .done        (div_done),
    .tag_out     (div_tag),
    .rd_out      (div_rd),
    .wdata       (div_wdata)
  );

  wb_arbiter wb_arbiter_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .alu_done  (alu_done),
    .alu_tag   (alu_tag),
    .alu_rd    (alu_rd),
    .alu_wdata (alu_wdata),
    .alu_wen   (alu_wen),
    .alu_exc   (alu_exc),
    .mul_done  (mul_done),
    .mul_tag   (mul_tag),
    .mul_rd    (mul_rd),
    .mul_wdata (mul_wdata),
    .div_done  (div_done),
    .div_tag   (div_tag),
    .div_rd    (div_rd),
    .div_wdata (div_wdata),
    .div_grant (div_grant),
    .cb_valid  (cb_valid),
    .cb_tag    (cb_tag),
    .cb_rd     (cb_rd),
    .cb_wdata  (cb_wdata),
    .cb_wen    (cb_wen),
    .cb_exc    (cb_exc)
  );

endmodule

// File: verilog/wb_arbiter.sv
// fixed-priority completion select, multiplier then ALU then divider
`timescale 1ns/1ps

module wb_arbiter (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                alu_done,
  input  exec_pkg::cb_idx_t   alu_tag,
  input  exec_pkg::reg_idx_t  alu_rd,
  input  exec_pkg::word_t     alu_wdata,
  input  logic                alu_wen,
  input  exec_pkg::exc_t      alu_exc,
  input  logic                mul_done,
  input  exec_pkg::cb_idx_t   mul_tag,
  input  exec_pkg::reg_idx_t  mul_rd,
  input  exec_pkg::word_t     mul_wdata,
  input  logic                div_done,
  input  exec_pkg::cb_idx_t   div_tag,
  input  exec_pkg::reg_idx_t  div_rd,
  input  exec_pkg::word_t     div_wdata,
  output logic                div_grant,
  output logic                cb_valid,
  output exec_pkg::cb_idx_t   cb_tag,
  output exec_pkg::reg_idx_t  cb_rd,
  output exec_pkg::word_t     cb_wdata,
  output logic                cb_wen,
  output exec_pkg::exc_t      cb_exc
);
  import exec_pkg::*;

  logic div_grant_q;
  logic div_ready;

  // one grant per divide result
  assign div_ready = div_done && !div_grant_q;
  assign div_grant = div_ready && !mul_done && !alu_done;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      div_grant_q <= 1'b0;
    end else begin
      div_grant_q <= div_grant;
    end
  end

  always_comb begin
    cb_valid = 1'b0;
    cb_tag   = '0;
    cb_rd    = '0;
    cb_wdata = '0;
    cb_wen   = 1'b0;
    cb_exc   = EXC_NONE;
    if (mul_done) begin
      cb_valid = 1'b1;
      cb_tag   = mul_tag;
      cb_rd    = mul_rd;
      cb_wdata = mul_wdata;
      cb_wen   = 1'b1;
    end else if (alu_done) begin
      cb_valid = 1'b1;
      cb_tag   = alu_tag;
      cb_rd    = alu_rd;
      cb_wdata = alu_wdata;
      cb_wen   = alu_wen;
      cb_exc   = alu_exc;
    end else if (div_ready) begin
      cb_valid = 1'b1;
      cb_tag   = div_tag;
      cb_rd    = div_rd;
      cb_wdata = div_wdata;
      cb_wen   = 1'b1;
    end
  end

endmodule

// File: verilog/div_iter.sv
// radix-2 restoring unsigned divider that holds its result until granted
`timescale 1ns/1ps

module div_iter (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                issue_valid,
  input  exec_pkg::fu_sel_t   fu_sel,
  input  exec_pkg::div_op_t   div_op,
  input  exec_pkg::word_t     port_a,
  input  exec_pkg::word_t     port_b,
  input  exec_pkg::cb_idx_t   tag,
  input  exec_pkg::reg_idx_t  rd,
  input  logic                grant,
  output logic                busy,
  output logic                done,
  output exec_pkg::cb_idx_t   tag_out,
  output exec_pkg::reg_idx_t  rd_out,
  output exec_pkg::word_t     wdata
);
  import exec_pkg::*;

  localparam int CNT_W = $clog2(DIV_CYCLES);

  logic             start;
  logic             running;
  logic             done_q;
  logic [CNT_W-1:0] cnt;
  word_t            acc;
  word_t            quo;
  word_t            dvsr;
  div_op_t          op_q;
  cb_idx_t          tag_q;
  reg_idx_t         rd_q;
  logic [XLEN:0]    shifted;
  logic [XLEN+1:0]  trial;

  assign start = issue_valid && (fu_sel == FU_DIV);

  // partial remainder with next dividend bit shifted in
  assign shifted = {acc, quo[XLEN-1]};
  assign trial   = {1'b0, shifted} - {2'b00, dvsr};

  // one step per cycle after the load, done on the last step
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      running <= 1'b0;
      done_q  <= 1'b0;
      cnt     <= '0;
    end else if (start) begin
      running <= 1'b1;
      done_q  <= 1'b0;
      cnt     <= CNT_W'(DIV_CYCLES - 1);
    end else if (running) begin
      cnt <= cnt - 1'b1;
      if (cnt == CNT_W'(1)) begin
        running <= 1'b0;
        done_q  <= 1'b1;
      end
    end else if (grant) begin
      done_q <= 1'b0;
    end
  end

  // a zero divisor always subtracts, so the quotient ends all ones
  // and the remainder ends as the dividend
  always_ff @(posedge CLK) begin
    if (start) begin
      acc   <= '0;
      quo   <= port_a;
      dvsr  <= port_b;
      op_q  <= div_op;
      tag_q <= tag;
      rd_q  <= rd;
    end else if (running) begin
      if (!trial[XLEN+1]) begin
        acc <= trial[XLEN-1:0];
        quo <= {quo[XLEN-2:0], 1'b1};
      end else begin
        acc <= shifted[XLEN-1:0];
        quo <= {quo[XLEN-2:0], 1'b0};
      end
    end
  end

  assign busy    = running || done_q;
  assign done    = done_q;
  assign tag_out = tag_q;
  assign rd_out  = rd_q;
  assign wdata   = (op_q == REMU) ? acc : quo;

endmodule

// File: verilog/mul_pipe.sv
// three-stage unsigned multiplier with tag and destination carried per stage
`timescale 1ns/1ps

module mul_pipe (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                issue_valid,
  input  exec_pkg::fu_sel_t   fu_sel,
  input  exec_pkg::mul_op_t   mul_op,
  input  exec_pkg::word_t     port_a,
  input  exec_pkg::word_t     port_b,
  input  exec_pkg::cb_idx_t   tag,
  input  exec_pkg::reg_idx_t  rd,
  output logic                done,
  output exec_pkg::cb_idx_t   tag_out,
  output exec_pkg::reg_idx_t  rd_out,
  output exec_pkg::word_t     wdata,
  output logic                near_done
);
  import exec_pkg::*;

  logic                  start;
  logic [MUL_STAGES-1:0] vld;
  cb_idx_t               tag_pipe [MUL_STAGES];
  reg_idx_t              rd_pipe  [MUL_STAGES];
  word_t                 a_q;
  word_t                 b_q;
  mul_op_t               op_s1;
  mul_op_t               op_s2;
  logic [2*XLEN-1:0]     prod_q;
  word_t                 res_q;

  assign start = issue_valid && (fu_sel == FU_MUL);

  // vld[0] is stage one
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      vld <= '0;
    end else begin
      vld <= {vld[MUL_STAGES-2:0], start};
    end
  end

  always_ff @(posedge CLK) begin
    tag_pipe[0] <= tag;
    rd_pipe[0]  <= rd;
    for (int i = 1; i < MUL_STAGES; i++) begin
      tag_pipe[i] <= tag_pipe[i-1];
      rd_pipe[i]  <= rd_pipe[i-1];
    end
  end

  // operands, then full product, then word select
  always_ff @(posedge CLK) begin
    if (start) begin
      a_q   <= port_a;
      b_q   <= port_b;
      op_s1 <= mul_op;
    end
    prod_q <= {{XLEN{1'b0}}, a_q} * {{XLEN{1'b0}}, b_q};
    op_s2  <= op_s1;
    res_q  <= (op_s2 == MULHU) ? prod_q[2*XLEN-1:XLEN] : prod_q[XLEN-1:0];
  end

  assign done      = vld[MUL_STAGES-1];
  assign near_done = vld[MUL_STAGES-2];
  assign tag_out   = tag_pipe[MUL_STAGES-1];
  assign rd_out    = rd_pipe[MUL_STAGES-1];
  assign wdata     = res_q;

endmodule

// File: verilog/int_alu.sv
// single-cycle integer ALU holding one writeback entry for ALU, branch and jump issues
`timescale 1ns/1ps

module int_alu (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                issue_valid,
  input  exec_pkg::fu_sel_t   fu_sel,
  input  exec_pkg::alu_op_t   alu_op,
  input  exec_pkg::word_t     port_a,
  input  exec_pkg::word_t     port_b,
  input  exec_pkg::word_t     pc,
  input  exec_pkg::word_t     pc4,
  input  exec_pkg::cb_idx_t   tag,
  input  exec_pkg::reg_idx_t  rd,
  input  logic                mal_target,
  output logic                done,
  output exec_pkg::cb_idx_t   tag_out,
  output exec_pkg::reg_idx_t  rd_out,
  output exec_pkg::word_t     wdata,
  output logic                wen,
  output exec_pkg::exc_t      exc
);
  import exec_pkg::*;

  logic  start;
  logic  is_branch;
  logic  is_jump;
  word_t alu_res;

  assign is_branch = (fu_sel == FU_BRANCH);
  assign is_jump   = (fu_sel == FU_JUMP);
  assign start     = issue_valid && ((fu_sel == FU_ALU) || is_branch || is_jump);

  always_comb begin
    case (alu_op)
      ADD:     alu_res = port_a + port_b;
      SUB:     alu_res = port_a - port_b;
      AND:     alu_res = port_a & port_b;
      OR:      alu_res = port_a | port_b;
      XOR:     alu_res = port_a ^ port_b;
      SLL:     alu_res = port_a << port_b[4:0];
      SRL:     alu_res = port_a >> port_b[4:0];
      SLTU:    alu_res = word_t'(port_a < port_b);
      default: alu_res = '0;
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      done <= 1'b0;
    end else begin
      done <= start;
    end
  end

  // faulting branch or jump reports its own pc
  always_ff @(posedge CLK) begin
    if (start) begin
      tag_out <= tag;
      rd_out  <= rd;
      wdata   <= mal_target ? pc : (is_jump ? pc4 : alu_res);
      wen     <= !is_branch && !mal_target;
      exc     <= mal_target ? EXC_MAL_TARGET : EXC_NONE;
    end
  end

endmodule

// File: verilog/branch_resolve.sv
// branch and jump resolution with target alignment check and registered redirect
`timescale 1ns/1ps

module branch_resolve (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               issue_valid,
  input  exec_pkg::fu_sel_t  fu_sel,
  input  exec_pkg::alu_op_t  alu_op,
  input  exec_pkg::word_t    port_a,
  input  exec_pkg::word_t    port_b,
  input  exec_pkg::word_t    imm,
  input  exec_pkg::word_t    pc,
  input  exec_pkg::word_t    pc4,
  input  logic               prediction,
  output logic               redirect_valid,
  output exec_pkg::word_t    redirect_addr,
  output logic               mal_target,
  output logic               link_sel
);
  import exec_pkg::*;

  logic  is_branch;
  logic  is_jump;
  logic  taken;
  word_t branch_target;
  word_t jump_target;
  word_t target;

  assign is_branch = issue_valid && (fu_sel == FU_BRANCH);
  assign is_jump   = issue_valid && (fu_sel == FU_JUMP);

  // condition reuses the alu_op encoding
  always_comb begin
    case (alu_op)
      ADD:     taken = (port_a == port_b);
      SUB:     taken = (port_a != port_b);
      AND:     taken = ($signed(port_a) < $signed(port_b));
      OR:      taken = ($signed(port_a) >= $signed(port_b));
      XOR:     taken = (port_a < port_b);
      SLL:     taken = (port_a >= port_b);
      default: taken = 1'b0;
    endcase
  end

  assign branch_target = pc + imm;
  // jal is pc relative, jalr clears bit 0
  assign jump_target   = (alu_op == ADD) ? (pc + imm) : ((port_a + imm) & ~word_t'(1));
  assign target        = is_jump ? jump_target : branch_target;

  assign mal_target = (is_branch || is_jump) && (target[1:0] != 2'b00);
  assign link_sel   = (is_branch || is_jump) && !mal_target;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      redirect_valid <= 1'b0;
    end else begin
      redirect_valid <= link_sel && (is_jump || (taken != prediction));
    end
  end

  // not-taken branches fall through to pc4
  always_ff @(posedge CLK) begin
    if (link_sel) begin
      redirect_addr <= (is_jump || taken) ? target : pc4;
    end
  end

endmodule

// File: verilog/exec_pkg.sv
// execute stage types, operation encodings and unit latencies
package exec_pkg;

  // datapath
  localparam int XLEN = 32;
  typedef logic [XLEN-1:0] word_t;

  // completion buffer and register file indices
  localparam int NUM_CB_ENTRY = 16;
  typedef logic [$clog2(NUM_CB_ENTRY)-1:0] cb_idx_t;
  typedef logic [4:0] reg_idx_t;

  typedef enum logic [2:0] {
    FU_ALU    = 3'd0,
    FU_MUL    = 3'd1,
    FU_DIV    = 3'd2,
    FU_BRANCH = 3'd3,
    FU_JUMP   = 3'd4
  } fu_sel_t;

  // also picks the branch condition
  typedef enum logic [2:0] {
    ADD  = 3'd0,
    SUB  = 3'd1,
    AND  = 3'd2,
    OR   = 3'd3,
    XOR  = 3'd4,
    SLL  = 3'd5,
    SRL  = 3'd6,
    SLTU = 3'd7
  } alu_op_t;

  typedef enum logic {
    MUL   = 1'b0,
    MULHU = 1'b1
  } mul_op_t;

  typedef enum logic {
    DIVU = 1'b0,
    REMU = 1'b1
  } div_op_t;

  typedef enum logic {
    EXC_NONE       = 1'b0,
    EXC_MAL_TARGET = 1'b1
  } exc_t;

  // issue to writeback, in cycles
  localparam int MUL_STAGES = 3;
  localparam int DIV_CYCLES = XLEN + 1;

endpackage
